/* compile.f */
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_if.sv
hdl/lsu_req_buffer.sv
hdl/lsu_bus_ctrl.sv
hdl/lsu_writeback.sv
hdl/lsu_top.sv
tb/tb_lsu_mem.sv
tb/tb_lsu.sv

/* hdl/lsu_bus_ctrl.sv */
// lsu bus controller: access FSM driving the AXI channels, store packing and split reads
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_bus_ctrl import lsu_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  lsu_req_if.snk                 req,
  lsu_ret_if.src                 ret,
  output logic                   busy_o,
  output logic [`LSU_ADDR_W-1:0] araddr_o,
  output logic                   arvalid_o,
  input  logic                   arready_i,
  input  logic                   rvalid_i,
  input  logic [`LSU_BUS_W-1:0]  rdata_i,
  input  logic [1:0]             rresp_i,
  output logic                   rready_o,
  output logic [`LSU_ADDR_W-1:0] awaddr_o,
  output logic                   awvalid_o,
  input  logic                   awready_i,
  output logic                   wvalid_o,
  output logic [`LSU_BUS_W-1:0]  wdata_o,
  output logic [`LSU_STRB_W-1:0] wstrb_o,
  input  logic                   wready_i,
  input  logic                   bvalid_i,
  input  logic [1:0]             bresp_i,
  output logic                   bready_o
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_RADDR, ST_RDATA, ST_WADDR, ST_WRESP, ST_PASS
  } state_t;

  state_t                 state_q;
  logic                   arvalid_q;
  logic                   awvalid_q;
  logic                   wvalid_q;
  logic                   rready_q;
  logic                   bready_q;
  logic                   done_q;
  logic                   second_q;
  logic [`LSU_ADDR_W-1:0] araddr_q;
  logic [`LSU_ADDR_W-1:0] addr_q;
  logic                   is_load_q;
  logic                   signed_q;
  logic [1:0]             size_q;
  logic [4:0]             rd_q;
  logic                   reg_en_q;
  logic                   split_q;
  logic [`LSU_BUS_W-1:0]  wdata_q;
  logic [`LSU_STRB_W-1:0] wstrb_q;
  lsu_beat_u              beat0_q;
  lsu_beat_u              beat1_q;
  logic                   take;
  logic                   crossing;
  logic                   store_aligned;
  logic                   ar_fire;
  logic                   r_fire;
  logic                   b_fire;
  logic [`LSU_STRB_W-1:0] size_mask;
  logic [`LSU_STRB_W-1:0] strb_pack;
  logic [`LSU_BUS_W-1:0]  wdata_pack;

  assign take    = (state_q == ST_IDLE) && req.valid;
  assign ar_fire = arvalid_q && arready_i;
  assign r_fire  = rvalid_i && rready_q;
  assign b_fire  = bvalid_i && bready_q;

  // half at offset 3 or word off a word boundary needs two reads
  assign crossing = req.ren &&
                    (((req.size == `LSU_SIZE_H) && (req.addr[1:0] == 2'b11)) ||
                     ((req.size == `LSU_SIZE_W) && (req.addr[1:0] != 2'b00)));

  assign store_aligned = (req.size == `LSU_SIZE_B) ||
                         ((req.size == `LSU_SIZE_H) && !req.addr[0]) ||
                         ((req.size == `LSU_SIZE_W) && (req.addr[1:0] == 2'b00));

  // move the bytes into their lanes of the 64-bit beat
  always_comb begin
    case (req.size)
      `LSU_SIZE_B: size_mask = 8'h01;
      `LSU_SIZE_H: size_mask = 8'h03;
      default:     size_mask = 8'h0f;
    endcase
    strb_pack  = size_mask << req.addr[2:0];
    wdata_pack = {{(`LSU_BUS_W-`LSU_XLEN){1'b0}}, req.wdata} << {req.addr[2:0], 3'b000};
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= ST_IDLE;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      rready_q  <= 1'b0;
      bready_q  <= 1'b0;
      done_q    <= 1'b0;
      second_q  <= 1'b0;
    end else begin
      rready_q <= 1'b1;
      bready_q <= 1'b1;
      done_q   <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req.valid) begin
            if (req.ren) begin
              arvalid_q <= 1'b1;
              state_q   <= ST_RADDR;
            end else if (req.wen) begin
              awvalid_q <= 1'b1;
              wvalid_q  <= 1'b1;
              state_q   <= ST_WADDR;
            end else begin
              state_q <= ST_PASS;
            end
          end
        end
        ST_RADDR: begin
          if (ar_fire) begin
            arvalid_q <= 1'b0;
            state_q   <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (r_fire) begin
            if (split_q && !second_q) begin
              // upper word next, at address plus 4
              second_q  <= 1'b1;
              arvalid_q <= 1'b1;
              state_q   <= ST_RADDR;
            end else begin
              second_q <= 1'b0;
              done_q   <= 1'b1;
              state_q  <= ST_IDLE;
            end
          end
        end
        ST_WADDR: begin
          // aw and w may complete in either order
          if (awready_i) begin
            awvalid_q <= 1'b0;
          end
          if (wready_i) begin
            wvalid_q <= 1'b0;
          end
          if ((!awvalid_q || awready_i) && (!wvalid_q || wready_i)) begin
            state_q <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          if (b_fire) begin
            done_q  <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        ST_PASS: begin
          done_q  <= 1'b1;
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      addr_q    <= req.addr;
      araddr_q  <= req.addr;
      is_load_q <= req.ren;
      signed_q  <= req.signed_ld;
      size_q    <= req.size;
      rd_q      <= req.rd;
      reg_en_q  <= req.reg_en;
      split_q   <= crossing;
      wdata_q   <= wdata_pack;
      wstrb_q   <= strb_pack;
    end
    if ((state_q == ST_RDATA) && r_fire) begin
      if (second_q) begin
        beat1_q <= rdata_i;
      end else begin
        beat0_q  <= rdata_i;
        araddr_q <= addr_q + `LSU_ADDR_W'(4);
      end
    end
  end

  assign req.take = take;
  assign busy_o   = (state_q != ST_IDLE);

  assign araddr_o  = araddr_q;
  assign arvalid_o = arvalid_q;
  assign rready_o  = rready_q;
  assign awaddr_o  = addr_q;
  assign awvalid_o = awvalid_q;
  assign wvalid_o  = wvalid_q;
  assign wdata_o   = wdata_q;
  assign wstrb_o   = wstrb_q;
  assign bready_o  = bready_q;

  assign ret.done      = done_q;
  assign ret.is_load   = is_load_q;
  assign ret.signed_ld = signed_q;
  assign ret.size      = size_q;
  assign ret.addr      = addr_q;
  assign ret.beat0     = beat0_q;
  assign ret.beat1     = beat1_q;
  assign ret.rd        = rd_q;
  assign ret.reg_en    = reg_en_q;

  a_rresp_okay: assert property (@(posedge clock) disable iff (reset)
    r_fire |-> rresp_i == `LSU_RESP_OKAY);
  a_bresp_okay: assert property (@(posedge clock) disable iff (reset)
    b_fire |-> bresp_i == `LSU_RESP_OKAY);
  // unaligned stores are not split
  a_store_aligned: assert property (@(posedge clock) disable iff (reset)
    take && req.wen && !req.ren |-> store_aligned);
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));
  a_w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o));

endmodule

/* hdl/lsu_if.sv */
// lsu internal interfaces: request path into the controller, return path to writeback
`timescale 1ns/100ps
`include "lsu_macros.svh"

interface lsu_req_if ();
  logic                   valid;
  logic                   ren;
  logic                   wen;
  logic                   signed_ld;
  logic [1:0]             size;
  logic [`LSU_ADDR_W-1:0] addr;
  logic [`LSU_XLEN-1:0]   wdata;
  logic [4:0]             rd;
  logic                   reg_en;
  logic                   take;

  modport src (output valid, ren, wen, signed_ld, size, addr, wdata, rd, reg_en, input take);
  modport snk (input valid, ren, wen, signed_ld, size, addr, wdata, rd, reg_en, output take);
endinterface

interface lsu_ret_if import lsu_pkg::*; ();
  logic                   done;
  logic                   is_load;
  logic                   signed_ld;
  logic [1:0]             size;
  logic [`LSU_ADDR_W-1:0] addr;
  lsu_beat_u              beat0;
  lsu_beat_u              beat1;
  logic [4:0]             rd;
  logic                   reg_en;

  modport src (output done, is_load, signed_ld, size, addr, beat0, beat1, rd, reg_en);
  modport snk (input done, is_load, signed_ld, size, addr, beat0, beat1, rd, reg_en);
endinterface

/* hdl/lsu_pkg.sv */
// lsu package: bus beat type seen as word lanes or as bytes
`include "lsu_macros.svh"

package lsu_pkg;

  // one 64-bit beat, word lanes for lane select, bytes for joining
  typedef union packed {
    logic [`LSU_BUS_W/`LSU_XLEN-1:0][`LSU_XLEN-1:0] w;
    logic [`LSU_STRB_W-1:0][7:0]                    b;
  } lsu_beat_u;

endpackage

/* hdl/lsu_req_buffer.sv */
// lsu request buffer: presents the live request or a held one while the controller is busy
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_req_buffer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req_valid_i,
  input  logic                   req_ren_i,
  input  logic                   req_wen_i,
  input  logic                   req_signed_i,
  input  logic [1:0]             req_size_i,
  input  logic [`LSU_ADDR_W-1:0] req_addr_i,
  input  logic [`LSU_XLEN-1:0]   req_wdata_i,
  input  logic [4:0]             req_rd_i,
  input  logic                   req_reg_en_i,
  output logic                   req_ready_o,
  lsu_req_if.src                 req
);

  logic                   held_q;
  logic                   ren_q;
  logic                   wen_q;
  logic                   signed_q;
  logic [1:0]             size_q;
  logic [`LSU_ADDR_W-1:0] addr_q;
  logic [`LSU_XLEN-1:0]   wdata_q;
  logic [4:0]             rd_q;
  logic                   reg_en_q;
  logic                   capture;

  // controller busy, so park the request for later
  assign capture = req_valid_i && !held_q && !req.take;

  always_ff @(posedge clock) begin
    if (reset) begin
      held_q <= 1'b0;
    end else if (capture) begin
      held_q <= 1'b1;
    end else if (req.take) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      ren_q    <= req_ren_i;
      wen_q    <= req_wen_i;
      signed_q <= req_signed_i;
      size_q   <= req_size_i;
      addr_q   <= req_addr_i;
      wdata_q  <= req_wdata_i;
      rd_q     <= req_rd_i;
      reg_en_q <= req_reg_en_i;
    end
  end

  // held entry is older, it always goes first
  assign req.valid     = held_q || req_valid_i;
  assign req.ren       = held_q ? ren_q    : req_ren_i;
  assign req.wen       = held_q ? wen_q    : req_wen_i;
  assign req.signed_ld = held_q ? signed_q : req_signed_i;
  assign req.size      = held_q ? size_q   : req_size_i;
  assign req.addr      = held_q ? addr_q   : req_addr_i;
  assign req.wdata     = held_q ? wdata_q  : req_wdata_i;
  assign req.rd        = held_q ? rd_q     : req_rd_i;
  assign req.reg_en    = held_q ? reg_en_q : req_reg_en_i;

  assign req_ready_o = !held_q;

  // a request while full would be dropped
  a_no_overrun: assert property (@(posedge clock) disable iff (reset)
    req_valid_i |-> !held_q);

endmodule

/* hdl/lsu_top.sv */
// lsu top: request buffer, bus controller and writeback stage for a small RISC-V core
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req_valid_i,
  input  logic                   req_ren_i,
  input  logic                   req_wen_i,
  input  logic                   req_signed_i,
  input  logic [1:0]             req_size_i,
  input  logic [`LSU_ADDR_W-1:0] req_addr_i,
  input  logic [`LSU_XLEN-1:0]   req_wdata_i,
  input  logic [4:0]             req_rd_i,
  input  logic                   req_reg_en_i,
  output logic                   req_ready_o,
  output logic                   busy_o,
  output logic                   wb_valid_o,
  output logic [`LSU_XLEN-1:0]   wb_data_o,
  output logic [4:0]             wb_rd_o,
  output logic                   wb_reg_en_o,
  output logic [`LSU_ADDR_W-1:0] araddr_o,
  output logic                   arvalid_o,
  input  logic                   arready_i,
  input  logic                   rvalid_i,
  input  logic [`LSU_BUS_W-1:0]  rdata_i,
  input  logic [1:0]             rresp_i,
  output logic                   rready_o,
  output logic [`LSU_ADDR_W-1:0] awaddr_o,
  output logic                   awvalid_o,
  input  logic                   awready_i,
  output logic                   wvalid_o,
  output logic [`LSU_BUS_W-1:0]  wdata_o,
  output logic [`LSU_STRB_W-1:0] wstrb_o,
  input  logic                   wready_i,
  input  logic                   bvalid_i,
  input  logic [1:0]             bresp_i,
  output logic                   bready_o
);

  lsu_req_if u_req_if ();
  lsu_ret_if u_ret_if ();

  lsu_req_buffer u_req_buffer (
    .clock        (clock),
    .reset        (reset),
    .req_valid_i  (req_valid_i),
    .req_ren_i    (req_ren_i),
    .req_wen_i    (req_wen_i),
    .req_signed_i (req_signed_i),
    .req_size_i   (req_size_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_rd_i     (req_rd_i),
    .req_reg_en_i (req_reg_en_i),
    .req_ready_o  (req_ready_o),
    .req          (u_req_if.src)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clock     (clock),
    .reset     (reset),
    .req       (u_req_if.snk),
    .ret       (u_ret_if.src),
    .busy_o    (busy_o),
    .araddr_o  (araddr_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .rvalid_i  (rvalid_i),
    .rdata_i   (rdata_i),
    .rresp_i   (rresp_i),
    .rready_o  (rready_o),
    .awaddr_o  (awaddr_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .wvalid_o  (wvalid_o),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .wready_i  (wready_i),
    .bvalid_i  (bvalid_i),
    .bresp_i   (bresp_i),
    .bready_o  (bready_o)
  );

  lsu_writeback u_writeback (
    .clock       (clock),
    .reset       (reset),
    .ret         (u_ret_if.snk),
    .wb_valid_o  (wb_valid_o),
    .wb_data_o   (wb_data_o),
    .wb_rd_o     (wb_rd_o),
    .wb_reg_en_o (wb_reg_en_o)
  );

endmodule

/* hdl/lsu_writeback.sv */
// lsu writeback: picks load bytes from the returned beats, extends them and registers the result
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_writeback import lsu_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  lsu_ret_if.snk               ret,
  output logic                 wb_valid_o,
  output logic [`LSU_XLEN-1:0] wb_data_o,
  output logic [4:0]           wb_rd_o,
  output logic                 wb_reg_en_o
);

  logic                 split;
  lsu_beat_u            joined;
  logic [`LSU_XLEN-1:0] raw;
  logic [`LSU_XLEN-1:0] ext;
  logic                 wb_valid_q;
  logic [`LSU_XLEN-1:0] wb_data_q;
  logic [4:0]           wb_rd_q;
  logic                 wb_reg_en_q;

  assign split = ((ret.size == `LSU_SIZE_H) && (ret.addr[1:0] == 2'b11)) ||
                 ((ret.size == `LSU_SIZE_W) && (ret.addr[1:0] != 2'b00));

  always_comb begin
    // low word from the first beat, next word from the second read
    joined.w[0] = ret.beat0.w[ret.addr[2]];
    joined.w[1] = split ? ret.beat1.w[!ret.addr[2]] : '0;
    for (int i = 0; i < 4; i++) begin
      raw[8*i +: 8] = joined.b[ret.addr[1:0] + i];
    end
    case (ret.size)
      `LSU_SIZE_B: ext = {{24{ret.signed_ld && raw[7]}}, raw[7:0]};
      `LSU_SIZE_H: ext = {{16{ret.signed_ld && raw[15]}}, raw[15:0]};
      default:     ext = raw;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= ret.done;
    end
  end

  always_ff @(posedge clock) begin
    if (ret.done) begin
      // non-loads carry the alu result
      wb_data_q   <= ret.is_load ? ext : ret.addr;
      wb_rd_q     <= ret.rd;
      wb_reg_en_q <= ret.reg_en;
    end
  end

  assign wb_valid_o  = wb_valid_q;
  assign wb_data_o   = wb_data_q;
  assign wb_rd_o     = wb_rd_q;
  assign wb_reg_en_o = wb_reg_en_q;

endmodule

/* include/lsu_macros.svh */
// lsu macros: bus and register widths, access-size codes and bus response codes
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// address and register word widths
`define LSU_ADDR_W 32
`define LSU_XLEN   32

// 64-bit data bus, one strobe bit per byte
`define LSU_BUS_W  64
`define LSU_STRB_W 8

// access size, as carried on the request
`define LSU_SIZE_B 2'd0
`define LSU_SIZE_H 2'd1
`define LSU_SIZE_W 2'd2

// rresp / bresp okay code
`define LSU_RESP_OKAY 2'b00

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the lsu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_lsu -o tb_lsu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_lsu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
fi

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

/* tb/lsu_golden.dat */
// kind size signed addr wdata rd expected
// kind 0 alu pass, 1 load, 2 store; stores and passes write back their address
2 2 0 00000100 11223344 01 00000100
1 2 0 00000100 00000000 02 11223344
2 2 0 00000104 8899aabb 03 00000104
2 2 0 00000108 cafef00d 04 00000108
1 2 0 00000101 00000000 05 bb112233
1 2 0 00000102 00000000 06 aabb1122
1 2 0 00000103 00000000 07 99aabb11
1 2 0 00000106 00000000 08 f00d8899
1 1 1 00000103 00000000 09 ffffbb11
1 1 0 00000103 00000000 0a 0000bb11
2 0 0 00000110 12345681 0b 00000110
2 0 0 00000111 1234567f 0c 00000111
2 0 0 00000112 abcdef00 0d 00000112
2 0 0 00000113 000000ff 0e 00000113
2 0 0 00000114 ffffff80 0f 00000114
2 0 0 00000115 00000001 10 00000115
2 0 0 00000116 555555c3 11 00000116
2 0 0 00000117 0000003c 12 00000117
1 0 1 00000110 00000000 13 ffffff81
1 0 0 00000111 00000000 14 0000007f
1 0 1 00000112 00000000 15 00000000
1 0 0 00000113 00000000 16 000000ff
1 0 1 00000114 00000000 17 ffffff80
1 0 1 00000115 00000000 18 00000001
1 0 0 00000116 00000000 19 000000c3
1 0 1 00000117 00000000 1a 0000003c
1 2 0 00000110 00000000 1b ff007f81
1 2 0 00000114 00000000 1c 3cc30180
2 1 0 00000118 dead8001 1d 00000118
2 1 0 0000011a 00007ffe 1e 0000011a
2 1 0 0000011c beefffff 1f 0000011c
2 1 0 0000011e 00001234 01 0000011e
1 1 1 00000118 00000000 02 ffff8001
1 1 0 0000011a 00000000 03 00007ffe
1 1 1 0000011c 00000000 04 ffffffff
1 1 0 0000011c 00000000 05 0000ffff
1 1 1 0000011e 00000000 06 00001234
0 0 0 00abcdef 00000000 07 00abcdef
1 2 1 00000103 00000000 08 99aabb11

/* tb/tb_lsu.sv */
// lsu testbench replaying golden requests singly and back to back and checking every writeback
`timescale 1ns/100ps
`include "lsu_macros.svh"

module tb_lsu;

  localparam int MAX_REQ = 64;
  localparam int COLS    = 7;

  logic                   clock;
  logic                   reset;
  logic                   req_valid, req_ren, req_wen, req_signed, req_reg_en;
  logic [1:0]             req_size;
  logic [`LSU_ADDR_W-1:0] req_addr;
  logic [`LSU_XLEN-1:0]   req_wdata;
  logic [4:0]             req_rd;
  logic                   req_ready_o, busy_o, wb_valid_o, wb_reg_en_o;
  logic [`LSU_XLEN-1:0]   wb_data_o;
  logic [4:0]             wb_rd_o;
  logic [`LSU_ADDR_W-1:0] araddr_o, awaddr_o;
  logic                   arvalid_o, arready, rvalid, rready_o;
  logic                   awvalid_o, awready, wvalid_o, wready, bvalid, bready_o;
  logic [`LSU_BUS_W-1:0]  rdata, wdata_o;
  logic [`LSU_STRB_W-1:0] wstrb_o;
  logic [1:0]             rresp, bresp;

  logic [31:0]            gold [0:MAX_REQ*COLS-1];
  int                     n_req;
  int                     value_errors;
  int                     other_errors;
  int                     cycle_count;
  int                     cycle_limit;
  logic [31:0]            ar_addrs [$];
  logic [`LSU_ADDR_W-1:0] aw_addrs [$];
  logic [`LSU_STRB_W-1:0] w_strbs [$];
  logic [`LSU_BUS_W-1:0]  w_beats [$];
  int                     expect_q [$];
  bit                     saw_full;

  lsu_top u_lsu_top (
    .clock (clock), .reset (reset),
    .req_valid_i (req_valid), .req_ren_i (req_ren), .req_wen_i (req_wen),
    .req_signed_i (req_signed), .req_size_i (req_size), .req_addr_i (req_addr),
    .req_wdata_i (req_wdata), .req_rd_i (req_rd), .req_reg_en_i (req_reg_en),
    .req_ready_o (req_ready_o), .busy_o (busy_o),
    .wb_valid_o (wb_valid_o), .wb_data_o (wb_data_o), .wb_rd_o (wb_rd_o),
    .wb_reg_en_o (wb_reg_en_o),
    .araddr_o (araddr_o), .arvalid_o (arvalid_o), .arready_i (arready),
    .rvalid_i (rvalid), .rdata_i (rdata), .rresp_i (rresp), .rready_o (rready_o),
    .awaddr_o (awaddr_o), .awvalid_o (awvalid_o), .awready_i (awready),
    .wvalid_o (wvalid_o), .wdata_o (wdata_o), .wstrb_o (wstrb_o), .wready_i (wready),
    .bvalid_i (bvalid), .bresp_i (bresp), .bready_o (bready_o)
  );

  tb_lsu_mem u_mem (
    .clock (clock), .reset (reset),
    .araddr_i (araddr_o), .arvalid_i (arvalid_o), .arready_o (arready),
    .rvalid_o (rvalid), .rdata_o (rdata), .rresp_o (rresp), .rready_i (rready_o),
    .awaddr_i (awaddr_o), .awvalid_i (awvalid_o), .awready_o (awready),
    .wvalid_i (wvalid_o), .wdata_i (wdata_o), .wstrb_i (wstrb_o), .wready_o (wready),
    .bvalid_o (bvalid), .bresp_o (bresp), .bready_i (bready_o)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // record every address and write-data handshake
  always @(posedge clock) begin
    if (!reset && arvalid_o && arready) begin
      ar_addrs.push_back(araddr_o);
    end
    if (!reset && awvalid_o && awready) begin
      aw_addrs.push_back(awaddr_o);
    end
    if (!reset && wvalid_o && wready) begin
      w_strbs.push_back(wstrb_o);
      w_beats.push_back(wdata_o);
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] field(int idx, int col);
    return gold[idx*COLS + col];
  endfunction

  // half at offset 3 or word off a word boundary
  function automatic bit needs_two_reads(int idx);
    return (field(idx, 1) == 1 && 2'(field(idx, 3)) == 2'b11) ||
           (field(idx, 1) == 2 && 2'(field(idx, 3)) != 2'b00);
  endfunction

  task automatic drive_req(int idx);
    req_valid  = 1'b1;
    req_ren    = (field(idx, 0) == 1);
    req_wen    = (field(idx, 0) == 2);
    req_size   = 2'(field(idx, 1));
    req_signed = 1'(field(idx, 2));
    req_addr   = field(idx, 3);
    req_wdata  = field(idx, 4);
    req_rd     = 5'(field(idx, 5));
    // alternate reg_en between requests
    req_reg_en = !idx[0];
  endtask

  task automatic clear_req();
    req_valid = 1'b0;
    req_ren   = 1'b0;
    req_wen   = 1'b0;
  endtask

  task automatic check_wb(int idx);
    assert (wb_data_o === field(idx, 6)) else begin
      $display("[FAIL] %0t req %0d data %h, expected %h", $time, idx, wb_data_o, field(idx, 6));
      value_errors++;
    end
    assert (wb_rd_o === 5'(field(idx, 5)) && wb_reg_en_o === !idx[0]) else begin
      $display("[FAIL] %0t req %0d rd %0d en %b, expected rd %0d en %b", $time, idx,
               wb_rd_o, wb_reg_en_o, field(idx, 5), !idx[0]);
      value_errors++;
    end
  endtask

  // expected lanes built byte by byte from the offset and the access size
  task automatic check_store(int idx);
    logic [`LSU_STRB_W-1:0] exp_strb;
    logic [`LSU_BUS_W-1:0]  exp_beat;
    logic [`LSU_BUS_W-1:0]  lane_mask;
    logic [31:0]            data;
    int                     off;
    int                     n_bytes;
    off       = int'(field(idx, 3) % 8);
    n_bytes   = 1 << field(idx, 1);
    data      = field(idx, 4);
    exp_strb  = '0;
    exp_beat  = '0;
    lane_mask = '0;
    for (int k = 0; k < n_bytes; k++) begin
      exp_strb[off + k]           = 1'b1;
      exp_beat[8*(off + k) +: 8]  = data[8*k +: 8];
      lane_mask[8*(off + k) +: 8] = 8'hff;
    end
    assert (aw_addrs.size() == 1 && w_strbs.size() == 1) else begin
      $display("[FAIL] %0t req %0d saw %0d aw and %0d w handshakes, expected 1 each",
               $time, idx, aw_addrs.size(), w_strbs.size());
      value_errors++;
    end
    if (aw_addrs.size() == 1 && w_strbs.size() == 1) begin
      assert (aw_addrs[0] == field(idx, 3)) else begin
        $display("[FAIL] %0t req %0d write address %h, expected %h", $time, idx,
                 aw_addrs[0], field(idx, 3));
        value_errors++;
      end
      assert (w_strbs[0] == exp_strb && (w_beats[0] & lane_mask) == exp_beat) else begin
        $display("[FAIL] %0t req %0d strobe %h data %h, expected strobe %h data %h", $time,
                 idx, w_strbs[0], w_beats[0] & lane_mask, exp_strb, exp_beat);
        value_errors++;
      end
    end
  endtask

  task automatic run_single(int idx);
    int lat;
    int exp_ar;
    ar_addrs.delete();
    aw_addrs.delete();
    w_strbs.delete();
    w_beats.delete();
    drive_req(idx);
    @(negedge clock);
    clear_req();
    lat = 1;
    while (!wb_valid_o) begin
      @(negedge clock);
      lat++;
    end
    check_wb(idx);
    // third edge counting the accepting one
    if (field(idx, 0) == 0) begin
      assert (lat == 3) else begin
        $display("[FAIL] %0t req %0d pass latency %0d, expected 3", $time, idx, lat);
        value_errors++;
      end
    end
    if (field(idx, 0) == 1) begin
      exp_ar = needs_two_reads(idx) ? 2 : 1;
      assert (ar_addrs.size() == exp_ar) else begin
        $display("[FAIL] %0t req %0d saw %0d reads, expected %0d", $time, idx,
                 ar_addrs.size(), exp_ar);
        value_errors++;
      end
      if (ar_addrs.size() == exp_ar) begin
        assert (ar_addrs[0] == field(idx, 3) &&
                (exp_ar == 1 || ar_addrs[1] == field(idx, 3) + 4)) else begin
          $display("[FAIL] %0t req %0d wrong read address", $time, idx);
          value_errors++;
        end
      end
    end
    if (field(idx, 0) == 2) begin
      check_store(idx);
    end
  endtask

  initial begin
    int issued;
    int returned;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_ren      = 1'b0;
    req_wen      = 1'b0;
    req_signed   = 1'b0;
    req_size     = 2'd0;
    req_addr     = '0;
    req_wdata    = '0;
    req_rd       = '0;
    req_reg_en   = 1'b0;
    value_errors = 0;
    other_errors = 0;
    cycle_count  = 0;
    cycle_limit  = 100000;
    saw_full     = 1'b0;
    for (int i = 0; i < MAX_REQ*COLS; i++) begin
      gold[i] = 'x;
    end
    $readmemh("tb/lsu_golden.dat", gold);
    n_req = 0;
    while (n_req < MAX_REQ && !$isunknown(gold[n_req*COLS])) begin
      n_req++;
    end
    // both passes count
    cycle_limit = 40 * 2 * n_req + 100;

    repeat (5) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    assert (!wb_valid_o && !arvalid_o && !awvalid_o && !wvalid_o && !busy_o && req_ready_o)
      else begin
        $display("[FAIL] %0t outputs not in their reset state", $time);
        value_errors++;
      end
    assert (rready_o && bready_o) else begin
      $display("[FAIL] %0t rready or bready not high one cycle after reset", $time);
      value_errors++;
    end

    for (int i = 0; i < n_req; i++) begin
      run_single(i);
    end

    // back to back as fast as ready allows
    issued   = 0;
    returned = 0;
    while (returned < n_req) begin
      @(negedge clock);
      if (wb_valid_o) begin
        if (expect_q.size() == 0) begin
          $display("writeback arrived with no request outstanding");
          other_errors++;
        end else begin
          check_wb(expect_q.pop_front());
        end
        returned++;
      end
      if (!req_ready_o) begin
        saw_full = 1'b1;
      end
      if (issued < n_req && req_ready_o) begin
        drive_req(issued);
        expect_q.push_back(issued);
        issued++;
      end else begin
        clear_req();
      end
    end
    assert (saw_full) else begin
      $display("request buffer never filled during the back-to-back run");
      other_errors++;
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tb/tb_lsu_mem.sv */
// lsu test memory: 64-bit AXI-style slave with random ready and response delays
`timescale 1ns/100ps
`include "lsu_macros.svh"

module tb_lsu_mem (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`LSU_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  output logic                   rvalid_o,
  output logic [`LSU_BUS_W-1:0]  rdata_o,
  output logic [1:0]             rresp_o,
  input  logic                   rready_i,
  input  logic [`LSU_ADDR_W-1:0] awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  logic                   wvalid_i,
  input  logic [`LSU_BUS_W-1:0]  wdata_i,
  input  logic [`LSU_STRB_W-1:0] wstrb_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  output logic [1:0]             bresp_o,
  input  logic                   bready_i
);

  logic [`LSU_BUS_W-1:0]  mem [0:255];
  integer                 seed;
  logic                   rd_pend;
  logic [`LSU_ADDR_W-1:0] rd_addr;
  logic                   aw_got;
  logic                   w_got;
  logic [`LSU_ADDR_W-1:0] wr_addr;
  logic [`LSU_BUS_W-1:0]  wr_data;
  logic [`LSU_STRB_W-1:0] wr_strb;

  // high about three times in four
  function automatic logic coin();
    return ($random(seed) & 3) != 0;
  endfunction

  initial begin
    seed = 78615;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'(i) * 32'h01010101 ^ 32'ha5a5a5a5, ~(32'(i) << 3)};
    end
    arready_o = 1'b0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    rvalid_o  = 1'b0;
    bvalid_o  = 1'b0;
    rdata_o   = '0;
  end

  assign rresp_o = `LSU_RESP_OKAY;
  assign bresp_o = `LSU_RESP_OKAY;

  always @(posedge clock) begin
    if (reset) begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_pend   <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
    end else begin
      arready_o <= coin();
      awready_o <= coin();
      wready_o  <= coin();
      if (arvalid_i && arready_o) begin
        rd_pend <= 1'b1;
        rd_addr <= araddr_i;
      end
      if (rd_pend && !rvalid_o && coin()) begin
        rvalid_o <= 1'b1;
        rdata_o  <= mem[rd_addr[10:3]];
        rd_pend  <= 1'b0;
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end
      if (awvalid_i && awready_o && !aw_got) begin
        aw_got  <= 1'b1;
        wr_addr <= awaddr_i;
      end
      if (wvalid_i && wready_o && !w_got) begin
        w_got   <= 1'b1;
        wr_data <= wdata_i;
        wr_strb <= wstrb_i;
      end
      // both halves of the write in, so commit and respond
      if (aw_got && w_got && !bvalid_o && coin()) begin
        for (int b = 0; b < `LSU_STRB_W; b++) begin
          if (wr_strb[b]) begin
            mem[wr_addr[10:3]][8*b +: 8] <= wr_data[8*b +: 8];
          end
        end
        bvalid_o <= 1'b1;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

endmodule
